// ==== bench/split_node_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module split_node_tb;

	localparam int CLK_PERIOD_NS = 10;
	localparam int NUM_MSGS      = 200;
	localparam int CYC_PER_MSG   = 80;
	localparam int WATCHDOG_NS   = NUM_MSGS * CYC_PER_MSG * CLK_PERIOD_NS;
	localparam int ACK_WAIT      = 400;   // cycles per handshake phase.
	localparam int STALL_CYCLES  = 40;
	localparam int FIFO_DEPTH    = 4;
	localparam logic [31:0]        SEED     = 32'h3418_8817;
	localparam msg_pkg::msg_addr_t RANGE_LO = 6'd10;
	localparam msg_pkg::msg_addr_t RANGE_HI = 6'd40;

	logic                gch_clk, gch_reset, gch_ready;
	logic                in_req, in_ack;
	msg_pkg::msg_addr_t  in_dst, in_src, out0_dst, out0_src, out1_dst, out1_src;
	msg_pkg::msg_data_t  in_dat, out0_dat, out1_dat;
	msg_pkg::msg_redun_t in_red, out0_red, out1_red;
	logic [1:0]          out_req;
	logic [1:0]          out_ack = 2'b00;
	logic                stall0;
	logic [31:0]         drv_rng, rx_rng;
	int                  rx_wait [2];
	logic [1:0]          req_seen, out_req_q;
	logic                in_ack_q;
	logic [47:0]         exp0 [$];
	logic [47:0]         exp1 [$];
	int                  err_value = 0;
	int                  err_proto = 0;
	int                  err_test  = 0;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) clock_inst (.gch_clk, .gch_reset);

	split_node_top #(
		.FIFO_DEPTH(FIFO_DEPTH), .DEB_CKS(2),
		.OPER_1(msg_pkg::CMP_GE), .REF_VAL_1(RANGE_LO), .IS_RANGE(1'b1),
		.OPER_2(msg_pkg::CMP_LE), .REF_VAL_2(RANGE_HI)
	) split_node_top_inst (
		.gch_clk, .gch_reset, .gch_ready,
		.in_req, .in_ack, .in_dst, .in_src, .in_dat, .in_red,
		.out0_req(out_req[0]), .out0_ack(out_ack[0]), .out0_dst, .out0_src, .out0_dat,
		.out0_red,
		.out1_req(out_req[1]), .out1_ack(out_ack[1]), .out1_dst, .out1_src, .out1_dat,
		.out1_red
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic routes_to_out0(input msg_pkg::msg_addr_t dst);
		return (dst >= RANGE_LO) && (dst <= RANGE_HI);
	endfunction

	task automatic check_delivery(input int idx, input logic [47:0] got);
		logic [47:0] want;
		if ((idx == 0 && exp0.size() == 0) || (idx == 1 && exp1.size() == 0)) begin
			err_value++;
			$display("output %0d delivered a message that was never accepted: %h", idx, got);
		end else begin
			if (idx == 0) want = exp0.pop_front();
			else want = exp1.pop_front();
			assert (got == want) else begin
				err_value++;
				$display("[FAIL] fidelity_out%0d: expected %h, actual %h", idx, want, got);
			end
		end
	endtask

	task automatic wait_in_ack(input logic level);
		int cycles;
		cycles = 0;
		@(posedge gch_clk);
		while (in_ack !== level && cycles < ACK_WAIT) begin
			@(posedge gch_clk);
			cycles++;
		end
		assert (in_ack === level) else begin
			err_test++;
			$display("in_ack did not reach %0b within %0d cycles", level, ACK_WAIT);
		end
	endtask

	task automatic start_msg(input msg_pkg::msg_addr_t dst, input msg_pkg::msg_addr_t src,
		input msg_pkg::msg_data_t dat, input msg_pkg::msg_redun_t red);
		@(posedge gch_clk);
		#1;
		in_dst = dst;
		in_src = src;
		in_dat = dat;
		in_red = red;
		in_req = 1'b1;
	endtask

	task automatic finish_msg();
		wait_in_ack(1'b1);
		#1 in_req = 1'b0;
		wait_in_ack(1'b0);
	endtask

	task automatic send_msg(input msg_pkg::msg_addr_t dst, input msg_pkg::msg_addr_t src,
		input msg_pkg::msg_data_t dat, input msg_pkg::msg_redun_t red);
		start_msg(dst, src, dat, red);
		finish_msg();
	endtask

	task automatic wait_drained(input string what);
		int cycles;
		cycles = 0;
		while ((exp0.size() != 0 || exp1.size() != 0 || out_req != 2'b00 ||
			out_ack != 2'b00 || in_ack) && cycles < ACK_WAIT) begin
			@(posedge gch_clk);
			cycles++;
		end
		assert (cycles < ACK_WAIT) else begin
			err_test++;
			$display("%s: outputs still busy after %0d cycles", what, ACK_WAIT);
		end
	endtask

	// receiver models ack after a random delay and release after another.
	always @(posedge gch_clk) begin
		logic [1:0] ack_next;
		ack_next = out_ack;
		if (gch_reset) begin
			rx_rng   = ~SEED;
			req_seen = 2'b00;
			rx_wait  = '{0, 0};
			ack_next = 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (out_req[i] != req_seen[i]) begin
					rx_rng      = xorshift32(rx_rng);
					rx_wait[i]  = int'(rx_rng[2:0]);
					req_seen[i] = out_req[i];
				end else if (rx_wait[i] != 0) begin
					rx_wait[i] = rx_wait[i] - 1;
				end else if (!(i == 0 && stall0)) begin
					ack_next[i] = req_seen[i];
				end
			end
		end
		#1 out_ack = ack_next;
	end

	// scoreboard.
	always @(posedge gch_clk) begin
		if (gch_reset) begin
			in_ack_q  = 1'b0;
			out_req_q = 2'b00;
		end else begin
			if (in_ack && !in_ack_q) begin
				if (routes_to_out0(in_dst)) exp0.push_back({in_dst, in_src, in_dat, in_red});
				else exp1.push_back({in_dst, in_src, in_dat, in_red});
			end
			if (out_req[0] && !out_req_q[0])
				check_delivery(0, {out0_dst, out0_src, out0_dat, out0_red});
			if (out_req[1] && !out_req_q[1])
				check_delivery(1, {out1_dst, out1_src, out1_dat, out1_red});
			in_ack_q  = in_ack;
			out_req_q = out_req;
		end
	end

	a_route0: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(out_req[0]) |-> (out0_dst >= RANGE_LO && out0_dst <= RANGE_HI)) else begin
		err_value++;
		$display("[FAIL] routing_out0: expected dst in 10..40, actual %0d", out0_dst);
	end
	a_route1: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(out_req[1]) |-> (out1_dst < RANGE_LO || out1_dst > RANGE_HI)) else begin
		err_value++;
		$display("[FAIL] routing_out1: expected dst outside 10..40, actual %0d", out1_dst);
	end
	a_out0_req: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(out_req[0]) |-> !out_ack[0]) else begin
		err_proto++;
		$display("out0_req rose while out0_ack was still high");
	end
	a_out1_req: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(out_req[1]) |-> !out_ack[1]) else begin
		err_proto++;
		$display("out1_req rose while out1_ack was still high");
	end
	a_in_ack: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(in_ack) |-> in_req) else begin
		err_proto++;
		$display("in_ack rose while in_req was low");
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, run took longer than %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [31:0] fields;
		in_req  = 1'b0;
		in_dst  = '0;
		in_src  = '0;
		in_dat  = '0;
		in_red  = '0;
		stall0  = 1'b0;
		drv_rng = SEED;
		@(posedge gch_clk);
		while (gch_reset) @(posedge gch_clk);
		assert (!in_ack && out_req == 2'b00 && !gch_ready) else begin
			err_test++;
			$display("[FAIL] reset_state: expected 0/00/0, actual %0b/%b/%0b", in_ack, out_req,
				gch_ready);
		end
		#1;
		assert (gch_ready === 1'b1) else begin
			err_test++;
			$display("[FAIL] ready_rise: expected 1, actual %b", gch_ready);
		end

		// one-cycle req pulse must be filtered.
		@(posedge gch_clk);
		#1 in_dst = 6'd20;
		in_req = 1'b1;
		@(posedge gch_clk);
		#1 in_req = 1'b0;
		repeat (12) begin
			@(posedge gch_clk);
			assert (!in_ack && out_req == 2'b00) else begin
				err_test++;
				$display("[FAIL] debounce_glitch: expected 0/00, actual %0b/%b", in_ack, out_req);
			end
		end

		send_msg(6'd9, 6'd1, 32'h0000_0009, 4'h1);   // range edges.
		send_msg(6'd10, 6'd1, 32'h0000_000a, 4'h2);
		send_msg(6'd40, 6'd1, 32'h0000_0028, 4'h3);
		send_msg(6'd41, 6'd1, 32'h0000_0029, 4'h4);

		// sender register plus a full fifo hold five messages.
		wait_drained("before back-pressure");
		@(posedge gch_clk);
		#1 stall0 = 1'b1;
		for (int i = 0; i < FIFO_DEPTH + 1; i++)
			send_msg(6'd11 + 6'(i), 6'd2, 32'hb000_0000 + i, 4'h5);
		start_msg(6'd30, 6'd2, 32'hb000_00ff, 4'h6);
		repeat (STALL_CYCLES) begin
			@(posedge gch_clk);
			assert (!in_ack) else begin
				err_test++;
				$display("[FAIL] backpressure_hold: expected in_ack 0, actual %0b", in_ack);
			end
		end
		#1 stall0 = 1'b0;
		finish_msg();

		for (int n = 0; n < NUM_MSGS - 4 - (FIFO_DEPTH + 2); n++) begin
			drv_rng = xorshift32(drv_rng);
			fields  = drv_rng;
			drv_rng = xorshift32(drv_rng);
			send_msg(fields[5:0], fields[11:6], drv_rng, fields[15:12]);
			repeat (int'(fields[17:16])) @(posedge gch_clk);
		end

		wait_drained("end of run");
		assert (exp0.size() == 0 && exp1.size() == 0) else begin
			err_test++;
			$display("messages never delivered, %0d on output 0 and %0d on output 1",
				exp0.size(), exp1.size());
		end
		repeat (5) @(posedge gch_clk);
		$display("errors: routing/fidelity %0d, protocol %0d, directed %0d",
			err_value, err_proto, err_test);
		if (err_value + err_proto + err_test == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic gch_clk,
	output logic gch_reset
);

	initial begin
		gch_clk = 1'b0;
		forever #(PERIOD_NS / 2) gch_clk = ~gch_clk;
	end

	// released just after an edge like the other inputs.
	initial begin
		gch_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge gch_clk);
		#1 gch_reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/msg_pkg.sv
hdl/msg_chnl_if.sv
hdl/strobe_debouncer.sv
hdl/msg_fifo.sv
hdl/chnl_sender.sv
hdl/msg_splitter.sv
hdl/split_node_top.sv
bench/tb_clock.sv
bench/split_node_tb.sv

// ==== hdl/chnl_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module chnl_sender (
	input  logic                gch_clk,
	input  logic                gch_reset,
	input  logic                empty,
	output logic                pop,
	input  msg_pkg::msg_addr_t  rd_dst,
	input  msg_pkg::msg_addr_t  rd_src,
	input  msg_pkg::msg_data_t  rd_dat,
	input  msg_pkg::msg_redun_t rd_red,
	msg_chnl_if.snd             chnl
);

	msg_pkg::sender_state_t state;

	logic                req_q;
	msg_pkg::msg_addr_t  dst_q;
	msg_pkg::msg_addr_t  src_q;
	msg_pkg::msg_data_t  dat_q;
	msg_pkg::msg_redun_t red_q;

	// take the head as soon as the channel is free.
	assign pop = (state == msg_pkg::SND_IDLE) && !empty;

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			state <= msg_pkg::SND_IDLE;
			req_q <= 1'b0;
		end else begin
			case (state)
				msg_pkg::SND_IDLE: begin
					if (!empty) begin
						req_q <= 1'b1;
						state <= msg_pkg::SND_REQUEST;
					end
				end
				msg_pkg::SND_REQUEST: begin
					if (chnl.ack) begin
						req_q <= 1'b0;
						state <= msg_pkg::SND_WAIT_REL;
					end
				end
				msg_pkg::SND_WAIT_REL: begin
					if (!chnl.ack) state <= msg_pkg::SND_IDLE; // four-phase done.
				end
				default: state <= msg_pkg::SND_IDLE;
			endcase
		end
	end

	always_ff @(posedge gch_clk) begin
		if (pop) begin
			dst_q <= rd_dst;
			src_q <= rd_src;
			dat_q <= rd_dat;
			red_q <= rd_red;
		end
	end

	assign chnl.req = req_q;
	assign chnl.dst = dst_q;
	assign chnl.src = src_q;
	assign chnl.dat = dat_q;
	assign chnl.red = red_q;

	a_fields_stable: assert property (@(posedge gch_clk) disable iff (gch_reset)
		req_q && $past(req_q) |-> $stable({dst_q, src_q, dat_q, red_q}));

endmodule

`default_nettype wire

// ==== hdl/msg_chnl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one four-phase message channel.
interface msg_chnl_if;

	logic                 req;
	logic                 ack;
	msg_pkg::msg_addr_t   dst;
	msg_pkg::msg_addr_t   src;
	msg_pkg::msg_data_t   dat;
	msg_pkg::msg_redun_t  red;

	modport snd (
		output req,
		output dst,
		output src,
		output dat,
		output red,
		input  ack
	);

	modport rcv (
		input  req,
		input  dst,
		input  src,
		input  dat,
		input  red,
		output ack
	);

endinterface

`default_nettype wire

// ==== hdl/msg_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_fifo #(
	parameter int FIFO_DEPTH = msg_pkg::DEF_FIFO_DEPTH
) (
	input  logic                gch_clk,
	input  logic                gch_reset,
	input  logic                push,
	input  logic                pop,
	input  msg_pkg::msg_addr_t  wr_dst,
	input  msg_pkg::msg_addr_t  wr_src,
	input  msg_pkg::msg_data_t  wr_dat,
	input  msg_pkg::msg_redun_t wr_red,
	output msg_pkg::msg_addr_t  rd_dst,
	output msg_pkg::msg_addr_t  rd_src,
	output msg_pkg::msg_data_t  rd_dat,
	output msg_pkg::msg_redun_t rd_red,
	output logic                full,
	output logic                empty
);

	localparam int IDX_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	msg_pkg::msg_addr_t  mem_dst [FIFO_DEPTH];
	msg_pkg::msg_addr_t  mem_src [FIFO_DEPTH];
	msg_pkg::msg_data_t  mem_dat [FIFO_DEPTH];
	msg_pkg::msg_redun_t mem_red [FIFO_DEPTH];

	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic [CNT_W-1:0] count;

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);

	// head of queue.
	assign rd_dst = mem_dst[rd_idx];
	assign rd_src = mem_src[rd_idx];
	assign rd_dat = mem_dat[rd_idx];
	assign rd_red = mem_red[rd_idx];

	always_ff @(posedge gch_clk) begin
		if (push) begin
			mem_dst[wr_idx] <= wr_dst;
			mem_src[wr_idx] <= wr_src;
			mem_dat[wr_idx] <= wr_dat;
			mem_red[wr_idx] <= wr_red;
		end
	end

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_idx <= (wr_idx == IDX_W'(FIFO_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
			end
			if (pop) begin
				rd_idx <= (rd_idx == IDX_W'(FIFO_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_overflow: assert property (@(posedge gch_clk) disable iff (gch_reset)
		push |-> !full);
	a_no_underflow: assert property (@(posedge gch_clk) disable iff (gch_reset)
		pop |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/msg_pkg.sv ====
`default_nettype none

package msg_pkg;

	// message fields.
	typedef logic [5:0]  msg_addr_t;   // node address for dst and src.
	typedef logic [31:0] msg_data_t;
	typedef logic [3:0]  msg_redun_t;  // carried through untouched.

	// destination comparison operators.
	typedef enum logic [2:0] {
		CMP_GT,
		CMP_GE,
		CMP_LT,
		CMP_LE,
		CMP_EQ,
		CMP_NE
	} cmp_oper_t;

	// output channel sender FSM.
	typedef enum logic [1:0] {
		SND_IDLE,
		SND_REQUEST,
		SND_WAIT_REL
	} sender_state_t;

	// defaults for the top level parameters.
	localparam int DEF_FIFO_DEPTH = 4;
	localparam int DEF_DEB_CKS    = 2;

endpackage

`default_nettype wire

// ==== hdl/msg_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_splitter #(
	parameter int                 FIFO_DEPTH = msg_pkg::DEF_FIFO_DEPTH,
	parameter msg_pkg::cmp_oper_t OPER_1     = msg_pkg::CMP_GT,
	parameter msg_pkg::msg_addr_t REF_VAL_1  = '0,
	parameter bit                 IS_RANGE   = 1'b0,
	parameter msg_pkg::cmp_oper_t OPER_2     = msg_pkg::CMP_GT,
	parameter msg_pkg::msg_addr_t REF_VAL_2  = '0
) (
	input  logic    gch_clk,
	input  logic    gch_reset,
	output logic    ready,
	msg_chnl_if.rcv rcv,
	msg_chnl_if.snd snd0,
	msg_chnl_if.snd snd1
);

	function automatic logic dst_cmp(msg_pkg::cmp_oper_t op, msg_pkg::msg_addr_t lhs,
		msg_pkg::msg_addr_t rhs);
		case (op)
			msg_pkg::CMP_GT: return lhs > rhs;
			msg_pkg::CMP_GE: return lhs >= rhs;
			msg_pkg::CMP_LT: return lhs < rhs;
			msg_pkg::CMP_LE: return lhs <= rhs;
			msg_pkg::CMP_EQ: return lhs == rhs;
			msg_pkg::CMP_NE: return lhs != rhs;
			default:         return 1'b0;
		endcase
	endfunction

	logic ready_q;
	logic ack_q;
	logic match;
	logic take;
	logic push0, push1;
	logic pop0, pop1;
	logic full0, full1;
	logic empty0, empty1;

	msg_pkg::msg_addr_t  h0_dst, h0_src, h1_dst, h1_src;
	msg_pkg::msg_data_t  h0_dat, h1_dat;
	msg_pkg::msg_redun_t h0_red, h1_red;

	assign match = dst_cmp(OPER_1, rcv.dst, REF_VAL_1) &&
		(!IS_RANGE || dst_cmp(OPER_2, rcv.dst, REF_VAL_2));

	// a full target fifo stalls the input for both outputs.
	assign take  = ready_q && rcv.req && !ack_q;
	assign push0 = take && match && !full0;
	assign push1 = take && !match && !full1;

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			ready_q <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			if (push0 || push1) begin
				ack_q <= 1'b1;
			end else if (!rcv.req && ack_q) begin
				ack_q <= 1'b0; // release phase.
			end
		end
	end

	assign ready   = ready_q;
	assign rcv.ack = ack_q;

	msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0_inst (
		.gch_clk, .gch_reset, .push(push0), .pop(pop0),
		.wr_dst(rcv.dst), .wr_src(rcv.src), .wr_dat(rcv.dat), .wr_red(rcv.red),
		.rd_dst(h0_dst), .rd_src(h0_src), .rd_dat(h0_dat), .rd_red(h0_red),
		.full(full0), .empty(empty0)
	);

	msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo1_inst (
		.gch_clk, .gch_reset, .push(push1), .pop(pop1),
		.wr_dst(rcv.dst), .wr_src(rcv.src), .wr_dat(rcv.dat), .wr_red(rcv.red),
		.rd_dst(h1_dst), .rd_src(h1_src), .rd_dat(h1_dat), .rd_red(h1_red),
		.full(full1), .empty(empty1)
	);

	chnl_sender sender0_inst (
		.gch_clk, .gch_reset, .empty(empty0), .pop(pop0),
		.rd_dst(h0_dst), .rd_src(h0_src), .rd_dat(h0_dat), .rd_red(h0_red),
		.chnl(snd0)
	);

	chnl_sender sender1_inst (
		.gch_clk, .gch_reset, .empty(empty1), .pop(pop1),
		.rd_dst(h1_dst), .rd_src(h1_src), .rd_dat(h1_dat), .rd_red(h1_red),
		.chnl(snd1)
	);

	a_ack_after_req: assert property (@(posedge gch_clk) disable iff (gch_reset)
		$rose(ack_q) |-> rcv.req);

endmodule

`default_nettype wire

// ==== hdl/split_node_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module split_node_top #(
	parameter int                 FIFO_DEPTH = msg_pkg::DEF_FIFO_DEPTH,
	parameter int                 DEB_CKS    = msg_pkg::DEF_DEB_CKS,
	parameter msg_pkg::cmp_oper_t OPER_1     = msg_pkg::CMP_GT,
	parameter msg_pkg::msg_addr_t REF_VAL_1  = '0,
	parameter bit                 IS_RANGE   = 1'b0,
	parameter msg_pkg::cmp_oper_t OPER_2     = msg_pkg::CMP_GT,
	parameter msg_pkg::msg_addr_t REF_VAL_2  = '0
) (
	input  logic                gch_clk,
	input  logic                gch_reset,
	output logic                gch_ready,
	input  logic                in_req,
	output logic                in_ack,
	input  msg_pkg::msg_addr_t  in_dst,
	input  msg_pkg::msg_addr_t  in_src,
	input  msg_pkg::msg_data_t  in_dat,
	input  msg_pkg::msg_redun_t in_red,
	output logic                out0_req,
	input  logic                out0_ack,
	output msg_pkg::msg_addr_t  out0_dst,
	output msg_pkg::msg_addr_t  out0_src,
	output msg_pkg::msg_data_t  out0_dat,
	output msg_pkg::msg_redun_t out0_red,
	output logic                out1_req,
	input  logic                out1_ack,
	output msg_pkg::msg_addr_t  out1_dst,
	output msg_pkg::msg_addr_t  out1_src,
	output msg_pkg::msg_data_t  out1_dat,
	output msg_pkg::msg_redun_t out1_red
);

	msg_chnl_if in_chnl ();
	msg_chnl_if out0_chnl ();
	msg_chnl_if out1_chnl ();

	// fields need no filter as they are sampled under req.
	strobe_debouncer #(.DEB_CKS(DEB_CKS)) in_req_deb_inst (
		.gch_clk, .gch_reset, .raw(in_req), .stable(in_chnl.req));
	strobe_debouncer #(.DEB_CKS(DEB_CKS)) out0_ack_deb_inst (
		.gch_clk, .gch_reset, .raw(out0_ack), .stable(out0_chnl.ack));
	strobe_debouncer #(.DEB_CKS(DEB_CKS)) out1_ack_deb_inst (
		.gch_clk, .gch_reset, .raw(out1_ack), .stable(out1_chnl.ack));

	assign in_chnl.dst = in_dst;
	assign in_chnl.src = in_src;
	assign in_chnl.dat = in_dat;
	assign in_chnl.red = in_red;
	assign in_ack      = in_chnl.ack;

	assign out0_req = out0_chnl.req;
	assign out0_dst = out0_chnl.dst;
	assign out0_src = out0_chnl.src;
	assign out0_dat = out0_chnl.dat;
	assign out0_red = out0_chnl.red;

	assign out1_req = out1_chnl.req;
	assign out1_dst = out1_chnl.dst;
	assign out1_src = out1_chnl.src;
	assign out1_dat = out1_chnl.dat;
	assign out1_red = out1_chnl.red;

	msg_splitter #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.OPER_1(OPER_1), .REF_VAL_1(REF_VAL_1), .IS_RANGE(IS_RANGE),
		.OPER_2(OPER_2), .REF_VAL_2(REF_VAL_2)
	) splitter_inst (
		.gch_clk, .gch_reset, .ready(gch_ready),
		.rcv(in_chnl.rcv), .snd0(out0_chnl.snd), .snd1(out1_chnl.snd)
	);

endmodule

`default_nettype wire

// ==== hdl/strobe_debouncer.sv ====
`timescale 1ns/1ps
`default_nettype none

module strobe_debouncer #(
	parameter int DEB_CKS = msg_pkg::DEF_DEB_CKS
) (
	input  logic gch_clk,
	input  logic gch_reset,
	input  logic raw,
	output logic stable
);

	localparam int CNT_W = (DEB_CKS > 0) ? $clog2(DEB_CKS + 1) : 1;

	logic             raw_q;
	logic [CNT_W-1:0] stable_cnt;

	// counter restarts on every change of raw.
	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			raw_q      <= 1'b0;
			stable_cnt <= '0;
			stable     <= 1'b0;
		end else begin
			raw_q <= raw;
			if (raw != raw_q) begin
				stable_cnt <= '0;
			end else if (stable_cnt != CNT_W'(DEB_CKS)) begin
				stable_cnt <= stable_cnt + 1'b1; // saturates at DEB_CKS.
			end
			if (stable_cnt == CNT_W'(DEB_CKS)) begin
				stable <= raw_q;
			end
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the split node testbench with Verilator, run it, then scan the log.
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module split_node_tb -o split_node_sim \
	&& ./obj_dir/split_node_sim > "$LOG" 2>&1 \
	&& ! grep -q "SIMULATION FAILED" "$LOG" \
	&& echo "run ok, see $LOG" \
	|| { echo "run failed, see $LOG"; exit 1; }
